/* logic/psram_pkg.sv */
`default_nettype none

package psram_pkg;

	// ----------------------------------------------------------------------
	// sizes
	// ----------------------------------------------------------------------
	localparam int BYTE_ADDR_W = 22;			// host byte address
	localparam int WORD_ADDR_W = 21;			// controller word address
	localparam int LANE_W = 8;					// one byte lane
	localparam int N_LANE = 4;					// lanes per controller word
	localparam int N_CH = 2;					// two psram channels

	// busy time after an accepted command
	localparam int WAIT_CNT = 14;
	localparam int WAIT_CNT_W = $clog2(WAIT_CNT + 1);

	// ----------------------------------------------------------------------
	// host side, one per channel
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic rd;								// read strobe
		logic wr;								// write strobe
		logic [BYTE_ADDR_W-1:0] address;		// byte address
		logic [LANE_W-1:0] wdata;				// write byte
	} psram_host_req_t;

	typedef struct packed {
		logic busy;
		logic [LANE_W-1:0] rdata;				// addressed byte of last read
		logic rdata_en;							// level, held until next read
	} psram_host_rsp_t;

	// controller data word, raw or split into byte lanes
	typedef union packed {
		logic [N_LANE*LANE_W-1:0] raw;
		logic [N_LANE-1:0][LANE_W-1:0] lane;
	} psram_word_u;

	// ----------------------------------------------------------------------
	// controller side
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic cmd;								// 1 = write
		logic cmd_en;							// one-cycle pulse
		logic [WORD_ADDR_W-1:0] addr;
		psram_word_u wr_data;
		logic [N_LANE-1:0] mask;				// active low, per lane
	} psram_cmd_t;

	typedef struct packed {
		psram_word_u rd_data;
		logic rd_valid;							// one-cycle pulse with the word
	} psram_rsp_t;

endpackage

`default_nettype wire

/* logic/psram_port_ctrl.sv */
`default_nettype none

module psram_port_ctrl (
	input wire logic clk,
	input wire logic n_reset,
	input wire psram_pkg::psram_host_req_t req0,
	input wire psram_pkg::psram_host_req_t req1,
	input wire logic init_calib0,
	input wire logic init_calib1,
	input wire logic rd_valid0,
	input wire logic rd_valid1,
	output logic busy0,
	output logic busy1,
	output logic cmd_en0,
	output logic cmd_en1,
	output logic capture0,
	output logic capture1,
	output logic clear0,
	output logic clear1
);
	import psram_pkg::*;

	// ----------------------------------------------------------------------
	// per-channel views
	// ----------------------------------------------------------------------
	psram_host_req_t req [N_CH];
	logic [N_CH-1:0] calib;						// controller init done
	logic [N_CH-1:0] rd_valid;
	logic [N_CH-1:0] cnt_zero;					// wait counter idle
	logic [N_CH-1:0] accept;					// strobe taken this cycle
	logic [N_CH-1:0] rd_accept;					// accepted strobe is a read
	logic [N_CH-1:0] rd_pending;				// read out, no word yet
	logic [N_CH-1:0] busy;
	logic [N_CH-1:0] capture;
	logic [WAIT_CNT_W-1:0] wait_cnt [N_CH];

	assign req[0] = req0;
	assign req[1] = req1;
	assign calib = {init_calib1, init_calib0};
	assign rd_valid = {rd_valid1, rd_valid0};

	// ----------------------------------------------------------------------
	// accept logic, combinational so cmd_en goes out with the strobe
	// ----------------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < N_CH; i++) begin
			cnt_zero[i] = (wait_cnt[i] == '0);
			busy[i] = !calib[i] || !cnt_zero[i];
			accept[i] = (req[i].rd || req[i].wr) && !busy[i];	// ignored while busy
			rd_accept[i] = accept[i] && req[i].rd;
			capture[i] = rd_valid[i] && rd_pending[i];			// first word only
		end
	end

	// ----------------------------------------------------------------------
	// wait counters and read pending flags
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		for (int i = 0; i < N_CH; i++) begin
			if (!n_reset) begin
				wait_cnt[i] <= '0;
				rd_pending[i] <= 1'b0;
			end else begin
				if (accept[i]) begin
					wait_cnt[i] <= WAIT_CNT_W'(WAIT_CNT);	// busy from next cycle
				end else if (!cnt_zero[i]) begin
					wait_cnt[i] <= wait_cnt[i] - WAIT_CNT_W'(1);
				end
				if (rd_accept[i]) begin
					rd_pending[i] <= 1'b1;
				end else if (rd_valid[i]) begin
					rd_pending[i] <= 1'b0;		// later valids are dropped
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------
	assign busy0 = busy[0];
	assign busy1 = busy[1];
	assign cmd_en0 = accept[0];
	assign cmd_en1 = accept[1];
	assign capture0 = capture[0];
	assign capture1 = capture[1];
	assign clear0 = rd_accept[0];			// old byte dropped on a new read
	assign clear1 = rd_accept[1];

endmodule

`default_nettype wire

/* logic/psram_wdata_lane.sv */
`default_nettype none

module psram_wdata_lane (
	input wire psram_pkg::psram_host_req_t req,
	input wire logic cmd_en,
	output psram_pkg::psram_cmd_t cmd
);
	import psram_pkg::*;

	logic [N_LANE-1:0] mask;

	// active low mask, only the addressed byte lane is written
	always_comb begin
		if (!cmd_en) begin
			mask = 4'b1111;						// idle, nothing written
		end else if (req.address[0]) begin
			mask = 4'b1101;						// odd byte in lane 1
		end else begin
			mask = 4'b1110;						// even byte in lane 0
		end
	end

	always_comb begin
		cmd.cmd = req.wr;
		cmd.cmd_en = cmd_en;
		cmd.addr = req.address[BYTE_ADDR_W-1:1];	// drop byte select
		cmd.wr_data.lane = {N_LANE{req.wdata}};	// same byte in every lane
		cmd.mask = mask;
	end

endmodule

`default_nettype wire

/* logic/psram_rdata_lane.sv */
`default_nettype none

module psram_rdata_lane (
	input wire logic clk,
	input wire logic n_reset,
	input wire logic addr_lsb,
	input wire psram_pkg::psram_rsp_t rsp,
	input wire logic capture,
	input wire logic clear,
	output logic [psram_pkg::LANE_W-1:0] rdata,
	output logic rdata_en
);
	import psram_pkg::*;

	logic [LANE_W-1:0] lane_byte;				// addressed byte of the word
	logic [LANE_W-1:0] rdata_q;
	logic rdata_en_q;

	// ----------------------------------------------------------------------
	// lane select
	// ----------------------------------------------------------------------
	// only lanes 0 and 1 carry data, the word holds one 16-bit device word
	always_comb begin
		if (addr_lsb) begin
			lane_byte = rsp.rd_data.lane[1];
		end else begin
			lane_byte = rsp.rd_data.lane[0];
		end
	end

	// ----------------------------------------------------------------------
	// capture register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			rdata_q <= '0;
			rdata_en_q <= 1'b0;
		end else if (clear) begin
			rdata_q <= '0;						// new read started
			rdata_en_q <= 1'b0;
		end else if (capture) begin
			rdata_q <= lane_byte;
			rdata_en_q <= 1'b1;					// held until next clear
		end
	end

	assign rdata = rdata_q;
	assign rdata_en = rdata_en_q;

endmodule

`default_nettype wire

/* logic/psram_byte_ports.sv */
`default_nettype none

module psram_byte_ports (
	input wire logic clk,
	input wire logic n_reset,
	// host channels
	input wire psram_pkg::psram_host_req_t host_req0,
	input wire psram_pkg::psram_host_req_t host_req1,
	output psram_pkg::psram_host_rsp_t host_rsp0,
	output psram_pkg::psram_host_rsp_t host_rsp1,
	// word controller
	output psram_pkg::psram_cmd_t cmd0,
	output psram_pkg::psram_cmd_t cmd1,
	input wire psram_pkg::psram_rsp_t rsp0,
	input wire psram_pkg::psram_rsp_t rsp1,
	input wire logic init_calib0,
	input wire logic init_calib1
);

	logic busy0;
	logic busy1;
	logic cmd_en0;
	logic cmd_en1;
	logic capture0;
	logic capture1;
	logic clear0;
	logic clear1;
	logic [7:0] rdata0;
	logic [7:0] rdata1;
	logic rdata_en0;
	logic rdata_en1;

	// ----------------------------------------------------------------------
	// shared control, both channels
	// ----------------------------------------------------------------------
	psram_port_ctrl i_psram_port_ctrl (
		.clk			(clk),
		.n_reset		(n_reset),
		.req0			(host_req0),
		.req1			(host_req1),
		.init_calib0	(init_calib0),
		.init_calib1	(init_calib1),
		.rd_valid0		(rsp0.rd_valid),
		.rd_valid1		(rsp1.rd_valid),
		.busy0			(busy0),
		.busy1			(busy1),
		.cmd_en0		(cmd_en0),
		.cmd_en1		(cmd_en1),
		.capture0		(capture0),
		.capture1		(capture1),
		.clear0			(clear0),
		.clear1			(clear1)
	);

	// ----------------------------------------------------------------------
	// write lanes, request to command word
	// ----------------------------------------------------------------------
	psram_wdata_lane i_wdata_lane0 (
		.req	(host_req0),
		.cmd_en	(cmd_en0),
		.cmd	(cmd0)
	);

	psram_wdata_lane i_wdata_lane1 (
		.req	(host_req1),
		.cmd_en	(cmd_en1),
		.cmd	(cmd1)
	);

	// ----------------------------------------------------------------------
	// read lanes, address held by host until rdata_en
	// ----------------------------------------------------------------------
	psram_rdata_lane i_rdata_lane0 (
		.clk		(clk),
		.n_reset	(n_reset),
		.addr_lsb	(host_req0.address[0]),
		.rsp		(rsp0),
		.capture	(capture0),
		.clear		(clear0),
		.rdata		(rdata0),
		.rdata_en	(rdata_en0)
	);

	psram_rdata_lane i_rdata_lane1 (
		.clk		(clk),
		.n_reset	(n_reset),
		.addr_lsb	(host_req1.address[0]),
		.rsp		(rsp1),
		.capture	(capture1),
		.clear		(clear1),
		.rdata		(rdata1),
		.rdata_en	(rdata_en1)
	);

	// host responses
	assign host_rsp0 = '{busy: busy0, rdata: rdata0, rdata_en: rdata_en0};
	assign host_rsp1 = '{busy: busy1, rdata: rdata1, rdata_en: rdata_en1};

endmodule

`default_nettype wire

/* dv/psram_ctrl_model.sv */
`default_nettype none

module psram_ctrl_model (
	input wire logic clk,
	input wire logic n_reset,
	input wire psram_pkg::psram_cmd_t cmd0,
	input wire psram_pkg::psram_cmd_t cmd1,
	input wire logic [3:0] rd_lat0,			// read latency in cycles, 4 to 10
	input wire logic [3:0] rd_lat1,
	output psram_pkg::psram_rsp_t rsp0,
	output psram_pkg::psram_rsp_t rsp1,
	output logic init_calib0,
	output logic init_calib1
);
	import psram_pkg::*;

	localparam int CALIB_CYCLES = 20;		// init time after reset
	localparam int DEPTH = 256;				// 16-bit words per device

	psram_cmd_t cmd [N_CH];
	psram_rsp_t rsp [N_CH];
	logic [3:0] rd_lat [N_CH];
	logic [15:0] mem [N_CH][DEPTH];
	logic [7:0] rd_idx [N_CH];				// word of the read in flight
	logic [3:0] rd_cnt [N_CH];				// 0 = no read in flight
	logic [4:0] calib_cnt;

	assign cmd[0] = cmd0;
	assign cmd[1] = cmd1;
	assign rd_lat[0] = rd_lat0;
	assign rd_lat[1] = rd_lat1;
	assign rsp0 = rsp[0];
	assign rsp1 = rsp[1];

	// power-up content, every word and channel differ
	function automatic logic [15:0] fill_word(int ch, int w);
		logic [7:0] a;
		a = 8'(w);
		return {a ^ 8'h96, a ^ 8'h3c} ^ ((ch == 1) ? 16'h5555 : 16'h0000);
	endfunction

	// ----------------------------------------------------------------------
	// calibration
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			calib_cnt <= '0;
		end else if (calib_cnt != 5'(CALIB_CYCLES)) begin
			calib_cnt <= calib_cnt + 5'd1;
		end
	end

	assign init_calib0 = (calib_cnt == 5'(CALIB_CYCLES));	// both devices alike
	assign init_calib1 = (calib_cnt == 5'(CALIB_CYCLES));

	// ----------------------------------------------------------------------
	// word storage and read pipe
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		for (int c = 0; c < N_CH; c++) begin
			if (!n_reset) begin
				for (int w = 0; w < DEPTH; w++) begin
					mem[c][w] <= fill_word(c, w);
				end
				rd_cnt[c] <= '0;
				rd_idx[c] <= '0;
				rsp[c] <= '0;
			end else begin
				rsp[c].rd_valid <= 1'b0;			// pulse only
				if (cmd[c].cmd_en && cmd[c].cmd) begin
					// lanes 2 and 3 have no device bits behind them
					if (!cmd[c].mask[0]) begin
						mem[c][cmd[c].addr[7:0]][7:0] <= cmd[c].wr_data.lane[0];
					end
					if (!cmd[c].mask[1]) begin
						mem[c][cmd[c].addr[7:0]][15:8] <= cmd[c].wr_data.lane[1];
					end
				end else if (cmd[c].cmd_en) begin
					rd_cnt[c] <= rd_lat[c] - 4'd1;	// valid lands rd_lat after cmd
					rd_idx[c] <= cmd[c].addr[7:0];
				end else if (rd_cnt[c] == 4'd1) begin
					rsp[c].rd_data.raw <= {16'h0000, mem[c][rd_idx[c]]};
					rsp[c].rd_valid <= 1'b1;
					rd_cnt[c] <= '0;
				end else if (rd_cnt[c] != '0) begin
					rd_cnt[c] <= rd_cnt[c] - 4'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* dv/tb_psram_byte_ports.sv */
`default_nettype none

module tb_psram_byte_ports;
	import psram_pkg::*;

	localparam int CLK_HALF = 20;
	localparam int RESET_CYCLES = 8;
	localparam int WAIT_LIMIT = 100;			// cycles before a wait gives up
	localparam int N_RANDOM = 60;				// random ops per channel
	localparam int MEM_BYTES = 512;				// model depth in bytes

	logic clk;
	logic n_reset;
	psram_host_req_t req [N_CH];
	psram_host_rsp_t host_rsp0;
	psram_host_rsp_t host_rsp1;
	psram_cmd_t cmd0;
	psram_cmd_t cmd1;
	psram_rsp_t rsp0;
	psram_rsp_t rsp1;
	logic init_calib0;
	logic init_calib1;
	logic [3:0] rd_lat [N_CH];

	logic [7:0] shadow [N_CH][MEM_BYTES];		// expected device bytes
	logic [7:0] exp_byte [N_CH];
	logic [N_CH-1:0] read_open;					// strobe out, rdata_en not yet up
	logic [N_CH-1:0] en_seen;
	logic [31:0] rand_state [N_CH];
	int data_errors;
	int proto_errors;
	int timeouts;

	psram_byte_ports i_psram_byte_ports (
		.clk			(clk),
		.n_reset		(n_reset),
		.host_req0		(req[0]),
		.host_req1		(req[1]),
		.host_rsp0		(host_rsp0),
		.host_rsp1		(host_rsp1),
		.cmd0			(cmd0),
		.cmd1			(cmd1),
		.rsp0			(rsp0),
		.rsp1			(rsp1),
		.init_calib0	(init_calib0),
		.init_calib1	(init_calib1)
	);

	psram_ctrl_model i_psram_ctrl_model (
		.clk			(clk),
		.n_reset		(n_reset),
		.cmd0			(cmd0),
		.cmd1			(cmd1),
		.rd_lat0		(rd_lat[0]),
		.rd_lat1		(rd_lat[1]),
		.rsp0			(rsp0),
		.rsp1			(rsp1),
		.init_calib0	(init_calib0),
		.init_calib1	(init_calib1)
	);

	// ----------------------------------------------------------------------
	// expected values
	// ----------------------------------------------------------------------
	function automatic logic [7:0] fill_byte(int ch, logic [8:0] b);
		logic [7:0] w;
		w = b[8:1];								// word, lane from b[0]
		return w ^ (b[0] ? 8'h96 : 8'h3c) ^ ((ch == 1) ? 8'h55 : 8'h00);
	endfunction

	function automatic logic [7:0] expected_byte(int ch, logic [BYTE_ADDR_W-1:0] addr);
		return shadow[ch][addr[8:0]];			// device keeps 256 words only
	endfunction

	function automatic logic [31:0] next_rand(int ch);
		rand_state[ch] = rand_state[ch] * 32'd1664525 + 32'd1013904223;
		return rand_state[ch];
	endfunction

	function automatic psram_host_rsp_t rsp_of(int ch);
		return (ch == 0) ? host_rsp0 : host_rsp1;
	endfunction

	task automatic finish_run();
		$display("errors: %0d data, %0d protocol, %0d timeout", data_errors, proto_errors,
			timeouts);
		if (data_errors + proto_errors + timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	task automatic give_up(string what);
		timeouts++;
		$display("timeout at %0t: %s", $time, what);
	endtask

	// ----------------------------------------------------------------------
	// host side ops
	// ----------------------------------------------------------------------
	task automatic wait_idle(int ch);
		psram_host_rsp_t r;
		int n;
		n = 0;
		@(negedge clk);
		r = rsp_of(ch);
		while (r.busy !== 1'b0 && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk);
			r = rsp_of(ch);
		end
		if (r.busy !== 1'b0) begin
			give_up("busy never dropped before a strobe");
		end
	endtask

	// controller command in the cycle of an accepted strobe
	task automatic check_cmd(int ch, logic wr, logic [BYTE_ADDR_W-1:0] addr, logic [7:0] data);
		psram_cmd_t c;
		logic [WORD_ADDR_W-1:0] exp_addr;
		logic [N_LANE-1:0] exp_mask;
		c = (ch == 0) ? cmd0 : cmd1;
		exp_addr = WORD_ADDR_W'(addr >> 1);			// word holds two bytes
		exp_mask = ~(N_LANE'(1) << addr[0]);		// addressed lane low
		assert (c.cmd_en && c.cmd == wr && c.addr == exp_addr && c.mask == exp_mask
			&& (!wr || c.wr_data.raw == {data, data, data, data})) else begin
			proto_errors++;
			$display("error at %0t: cmd%0d got en %b wr %b addr %h mask %b data %h", $time, ch,
				c.cmd_en, c.cmd, c.addr, c.mask, c.wr_data.raw);
			$display("error at %0t: cmd%0d expected en 1 wr %b addr %h mask %b data %h", $time,
				ch, wr, exp_addr, exp_mask, {data, data, data, data});
		end
	endtask

	// strobe one cycle, address stays on the bus afterwards
	task automatic start_op(int ch, logic wr, logic [BYTE_ADDR_W-1:0] addr, logic [7:0] data);
		wait_idle(ch);
		@(posedge clk);
		req[ch] <= '{rd: !wr, wr: wr, address: addr, wdata: data};
		rd_lat[ch] <= 4'(4 + next_rand(ch) % 7);
		if (wr) begin
			shadow[ch][addr[8:0]] = data;		// accepted, busy was low
		end else begin
			exp_byte[ch] = expected_byte(ch, addr);
			read_open[ch] = 1'b1;
		end
		@(negedge clk);
		check_cmd(ch, wr, addr, data);
		@(posedge clk);
		req[ch].rd <= 1'b0;
		req[ch].wr <= 1'b0;
	endtask

	task automatic run_op(int ch, logic wr, logic [BYTE_ADDR_W-1:0] addr, logic [7:0] data);
		psram_host_rsp_t r;
		int n;
		start_op(ch, wr, addr, data);
		n = 0;
		@(negedge clk);
		r = rsp_of(ch);
		while (r.busy && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk);
			r = rsp_of(ch);
		end
		if (r.busy) begin
			give_up("busy stuck high after a command");
		end else begin
			assert (n == WAIT_CNT) else begin
				proto_errors++;
				$display("error at %0t: busy%0d width got %0d expected %0d", $time, ch, n,
					WAIT_CNT);
			end
		end
		n = 0;
		while (read_open[ch] && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk);
		end
		if (read_open[ch]) begin
			give_up("rdata_en never rose after a read");
		end
	endtask

	// write strobe in the cycle after an accepted one
	task automatic ignored_write(int ch, logic [BYTE_ADDR_W-1:0] addr, logic [7:0] data);
		psram_cmd_t c;
		psram_host_rsp_t r;
		@(posedge clk);
		req[ch] <= '{rd: 1'b0, wr: 1'b1, address: addr, wdata: data};
		@(negedge clk);
		c = (ch == 0) ? cmd0 : cmd1;
		r = rsp_of(ch);
		assert (r.busy && !c.cmd_en) else begin
			proto_errors++;
			$display("error at %0t: cmd_en%0d got %b expected 0 while busy", $time, ch, c.cmd_en);
		end
		@(posedge clk);
		req[ch].wr <= 1'b0;
	endtask

	task automatic random_traffic(int ch);
		logic [BYTE_ADDR_W-1:0] a;
		logic [31:0] x;
		logic [7:0] d;
		for (int i = 0; i < N_RANDOM; i++) begin
			a = BYTE_ADDR_W'(next_rand(ch));
			a[8:4] = 5'h00;						// 16 bytes, reads hit writes
			x = next_rand(ch);
			d = 8'(next_rand(ch));
			run_op(ch, x[7], a, d);
		end
	endtask

	// ----------------------------------------------------------------------
	// read compare, both channels
	// ----------------------------------------------------------------------
	always @(negedge clk) begin : read_check
		psram_host_rsp_t r;
		for (int c = 0; c < N_CH; c++) begin
			r = rsp_of(c);
			if (r.rdata_en && !en_seen[c]) begin
				assert (read_open[c] && r.rdata == exp_byte[c]) else begin
					data_errors++;
					$display("error at %0t: host_rsp%0d.rdata got %h expected %h", $time, c,
						r.rdata, exp_byte[c]);
				end
				read_open[c] = 1'b0;
			end else if (!r.rdata_en && en_seen[c]) begin
				assert (read_open[c]) else begin
					proto_errors++;
					$display("rdata_en on channel %0d dropped with no new read", c);
				end
			end
			en_seen[c] = r.rdata_en;
		end
	end

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	initial begin
		logic [BYTE_ADDR_W-1:0] a;
		logic [7:0] d;
		psram_host_rsp_t r;
		int n;
		n_reset = 1'b0;
		read_open = '0;
		en_seen = '0;
		data_errors = 0;
		proto_errors = 0;
		timeouts = 0;
		rand_state[0] = 32'd63307;
		rand_state[1] = next_rand(0);
		for (int c = 0; c < N_CH; c++) begin
			req[c] = '0;
			rd_lat[c] = 4'd4;
			exp_byte[c] = '0;
			for (int b = 0; b < MEM_BYTES; b++) begin
				shadow[c][b] = fill_byte(c, 9'(b));
			end
		end
		repeat (RESET_CYCLES) @(posedge clk);
		n_reset <= 1'b1;

		// busy tracks calibration on each channel
		n = 0;
		d = '0;
		while (d[1:0] !== 2'b11 && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk);
			for (int c = 0; c < N_CH; c++) begin
				r = rsp_of(c);
				d[c] = (c == 0) ? init_calib0 : init_calib1;
				assert (r.busy == !d[c] && !r.rdata_en) else begin
					proto_errors++;
					$display("error at %0t: busy%0d got %b expected %b", $time, c, r.busy, !d[c]);
				end
			end
		end
		if (d[1:0] !== 2'b11) begin
			give_up("init_calib never rose");
		end

		for (int c = 0; c < N_CH; c++) begin
			// write then read back, rdata_en held
			a = BYTE_ADDR_W'(next_rand(c));
			d = 8'(next_rand(c));
			run_op(c, 1'b1, a, d);
			run_op(c, 1'b0, a, 8'h00);
			repeat (5) @(negedge clk);
			r = rsp_of(c);
			assert (r.rdata_en) else begin
				proto_errors++;
				$display("rdata_en on channel %0d fell before the next read", c);
			end
			// even then odd byte of one word
			a = BYTE_ADDR_W'(next_rand(c)) & ~BYTE_ADDR_W'(1);
			run_op(c, 1'b1, a, d);
			run_op(c, 1'b1, a | BYTE_ADDR_W'(1), ~d);
			run_op(c, 1'b0, a, 8'h00);
			run_op(c, 1'b0, a | BYTE_ADDR_W'(1), 8'h00);
			// strobe while busy is dropped
			a = BYTE_ADDR_W'(next_rand(c));
			start_op(c, 1'b1, a, d ^ 8'h5a);
			ignored_write(c, a, d);
			run_op(c, 1'b0, a, 8'h00);
		end

		fork
			random_traffic(0);
			random_traffic(1);
		join
		repeat (2) @(negedge clk);
		finish_run();
	end

endmodule

`default_nettype wire

/* vlog.f */
logic/psram_pkg.sv
logic/psram_port_ctrl.sv
logic/psram_wdata_lane.sv
logic/psram_rdata_lane.sv
logic/psram_byte_ports.sv
dv/psram_ctrl_model.sv
dv/tb_psram_byte_ports.sv

/* Bender.yml */
package:
  name: psram_byte_ports

sources:
  - files:
      - logic/psram_pkg.sv
      - logic/psram_port_ctrl.sv
      - logic/psram_wdata_lane.sv
      - logic/psram_rdata_lane.sv
      - logic/psram_byte_ports.sv
  - target: test
    files:
      - dv/psram_ctrl_model.sv
      - dv/tb_psram_byte_ports.sv
